// File: common/mem_op_pkg.sv
// cpu side memory operation types and data request struct, imported where data ops are decoded

package mem_op_pkg;

	// one machine word on the cpu side
	typedef logic [31:0] word_t;

	// data port operation, held for one cycle by the cpu
	// loads are re-presented while the unit stalls
	typedef enum logic [2:0] {
		MEM_OP_NONE = 3'd0,
		MEM_OP_LW   = 3'd1,
		MEM_OP_LBS  = 3'd2,
		MEM_OP_LBU  = 3'd3,
		MEM_OP_SW   = 3'd4,
		MEM_OP_SB   = 3'd5
	} mem_op_t;

	// data port request
	// wdata only matters for stores
	typedef struct packed {
		mem_op_t op;
		word_t   addr;
		word_t   wdata;
	} data_req_t;

	// true for ops that end in a word write to memory
	function automatic logic mem_op_is_write(input mem_op_t op);
		return (op == MEM_OP_SW) || (op == MEM_OP_SB);
	endfunction

	// true for the three load flavours
	function automatic logic mem_op_is_load(input mem_op_t op);
		return (op == MEM_OP_LW) || (op == MEM_OP_LBS) || (op == MEM_OP_LBU);
	endfunction

endpackage

// File: common/dev_bus_pkg.sv
// physical memory port structs and the unit's access sequencing states, shared by unit and controller

package dev_bus_pkg;

	// request from the unit to the word-wide memory controller
	// addr is a byte address, the controller drops the low pair
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        is_write;
	} dev_req_t;

	// controller response
	// rdata is only meaningful while busy is low
	typedef struct packed {
		logic [31:0] rdata;
		logic        busy;
	} dev_rsp_t;

	// device access sequence inside the unit
	// reads (fetch or load) happen in ST_READ
	// a byte store passes through ST_SB_MERGE to pick up the upper bytes
	typedef enum logic [1:0] {
		ST_READ     = 2'd0,
		ST_SB_MERGE = 2'd1,
		ST_WRITE    = 2'd2
	} mmu_state_t;

endpackage

// File: mmu/mmu.sv
// memory management unit sharing one physical port between instruction fetch and the data port

`timescale 1ns/100ps

module mmu (
	input  logic                    clk,
	input  logic                    rst,

	// fetch side
	input  mem_op_pkg::word_t       instr_addr,
	output mem_op_pkg::word_t       instr_out,

	// data side
	// op is a one-cycle strobe, wdata is latched when the store is taken
	// addr is not latched and must stay put while busy is high
	input  mem_op_pkg::data_req_t   data_req,
	output mem_op_pkg::word_t       data_out,

	// stall to the cpu, raised in the same cycle as a store strobe
	output logic                    busy,

	// alignment flag for fetch or data address
	output logic                    misaligned,

	// physical memory port
	output dev_bus_pkg::dev_req_t   dev_req,
	input  dev_bus_pkg::dev_rsp_t   dev_rsp
);

	import mem_op_pkg::*;
	import dev_bus_pkg::*;

	mmu_state_t state;

	// word headed for memory
	// for a byte store only the low byte survives the merge
	word_t wdata_q;

	logic op_present;
	logic op_is_store;
	logic op_is_load;
	logic store_accept;

	assign op_present  = (data_req.op != MEM_OP_NONE);
	assign op_is_store = mem_op_is_write(data_req.op);
	assign op_is_load  = mem_op_is_load(data_req.op);

	// a store is only taken once the device has settled on the data address
	assign store_accept = (state == ST_READ) && !dev_rsp.busy && op_is_store;

	// fetch data is whatever the device returns
	assign instr_out = dev_rsp.rdata;

	// stall while sequencing, while the device waits, or on a fresh store
	assign busy = (state != ST_READ) || dev_rsp.busy || op_is_store;

	// low pair nonzero on fetch, or on data address when an op is present
	assign misaligned = (instr_addr[1:0] != 2'b00) ||
		(op_present && (data_req.addr[1:0] != 2'b00));

	// device side request
	always_comb begin
		// data address wins whenever a data op is in flight
		if (op_present || (state != ST_READ)) begin
			dev_req.addr = data_req.addr;
		end else begin
			dev_req.addr = instr_addr;
		end
		dev_req.wdata    = wdata_q;
		dev_req.is_write = (state == ST_WRITE);
	end

	// load formatting straight off the device read data
	always_comb begin
		data_out = '0;
		if (op_is_load) begin
			case (data_req.op)
				MEM_OP_LW:  data_out = dev_rsp.rdata;
				// sign extend the low byte
				MEM_OP_LBS: data_out = {{24{dev_rsp.rdata[7]}}, dev_rsp.rdata[7:0]};
				// zero extend the low byte
				MEM_OP_LBU: data_out = {24'h000000, dev_rsp.rdata[7:0]};
				default:    data_out = '0;
			endcase
		end
	end

	// access sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_READ;
		end else begin
			case (state)
				ST_READ: begin
					if (store_accept) begin
						// byte store needs the old word first
						if (data_req.op == MEM_OP_SB) begin
							state <= ST_SB_MERGE;
						end else begin
							state <= ST_WRITE;
						end
					end
				end
				// device already holds the data address, rdata is the old word
				ST_SB_MERGE: state <= ST_WRITE;
				// write commits on this edge
				ST_WRITE:    state <= ST_READ;
				default:     state <= ST_READ;
			endcase
		end
	end

	// write word register
	always_ff @(posedge clk) begin
		if (store_accept) begin
			wdata_q <= data_req.wdata;
		end else if (state == ST_SB_MERGE) begin
			// keep the new low byte, take bits 31 to 8 from memory
			wdata_q[31:8] <= dev_rsp.rdata[31:8];
		end
	end

endmodule

// File: src/mem_ctrl.sv
// word-wide memory controller with preset contents and read and write wait states, driven by the mmu

`timescale 1ns/100ps

module mem_ctrl #(
	// array depth in words
	parameter int MEM_WORDS  = 256,
	// busy cycles after a new read address
	parameter int READ_WAIT  = 1,
	// busy cycles after a write
	parameter int WRITE_WAIT = 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  dev_bus_pkg::dev_req_t dev_req,
	output dev_bus_pkg::dev_rsp_t dev_rsp
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	// counter wide enough for the longer of the two waits
	localparam int WAIT_MAX = (READ_WAIT > WRITE_WAIT) ? READ_WAIT : WRITE_WAIT;
	localparam int CNT_W = (WAIT_MAX < 1) ? 1 : $clog2(WAIT_MAX + 1);

	// the comparison cycle itself already counts as the first read wait
	localparam int READ_RELOAD = (READ_WAIT > 0) ? READ_WAIT - 1 : 0;

	logic [31:0] mem [MEM_WORDS];

	// address of the word currently presented on rdata
	logic [31:0] addr_q;

	// remaining busy cycles
	logic [CNT_W-1:0] wait_cnt;

	logic             addr_new;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	// byte address to word index, wrapping on the array depth
	function automatic logic [IDX_W-1:0] word_index(input logic [31:0] a);
		return IDX_W'((a >> 2) % MEM_WORDS);
	endfunction

	// preset contents so reads return something recognisable
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = (32'(i) * 32'h01010101) ^ 32'h80402010;
		end
	end

	assign addr_new = (dev_req.addr != addr_q);
	assign wr_idx   = word_index(dev_req.addr);

	// zero read wait means the array answers the live address
	assign rd_idx = (READ_WAIT == 0) ? word_index(dev_req.addr) : word_index(addr_q);

	// busy rises with the address change, before the edge that latches it
	assign dev_rsp.busy  = (wait_cnt != '0) || (addr_new && (READ_WAIT != 0));
	assign dev_rsp.rdata = mem[rd_idx];

	// address tracking and wait counter
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q   <= '0;
			wait_cnt <= '0;
		end else if (dev_req.is_write) begin
			// write holds the port for its own wait
			addr_q   <= dev_req.addr;
			wait_cnt <= CNT_W'(WRITE_WAIT);
		end else if (wait_cnt != '0) begin
			// finish the running wait before looking at a new address
			wait_cnt <= wait_cnt - 1'b1;
		end else if (addr_new) begin
			addr_q   <= dev_req.addr;
			wait_cnt <= CNT_W'(READ_RELOAD);
		end
	end

	// array write
	// the word lands on the edge of the is_write cycle
	always @(posedge clk) begin
		if (dev_req.is_write) begin
			mem[wr_idx] <= dev_req.wdata;
		end
	end

endmodule

// File: src/mem_subsys_top.sv
// memory subsystem top level, the mmu in front of the memory controller, instantiated by the testbench

`timescale 1ns/100ps

module mem_subsys_top #(
	// array depth in words
	parameter int MEM_WORDS  = 256,
	// busy cycles after a new read address
	parameter int READ_WAIT  = 1,
	// busy cycles after a write
	parameter int WRITE_WAIT = 2
) (
	input  logic                  clk,
	input  logic                  rst,

	// fetch port
	input  mem_op_pkg::word_t     instr_addr,
	output mem_op_pkg::word_t     instr_out,

	// data port, op strobed for one cycle
	input  mem_op_pkg::data_req_t data_req,
	output mem_op_pkg::word_t     data_out,

	// stall and alignment flags
	output logic                  busy,
	output logic                  misaligned
);

	import dev_bus_pkg::*;

	// physical port between the unit and the controller
	dev_req_t dev_req;
	dev_rsp_t dev_rsp;

	mmu mmu_inst (
		.clk        (clk),
		.rst        (rst),
		.instr_addr (instr_addr),
		.instr_out  (instr_out),
		.data_req   (data_req),
		.data_out   (data_out),
		.busy       (busy),
		.misaligned (misaligned),
		.dev_req    (dev_req),
		.dev_rsp    (dev_rsp)
	);

	// wait states live here only
	mem_ctrl #(
		.MEM_WORDS  (MEM_WORDS),
		.READ_WAIT  (READ_WAIT),
		.WRITE_WAIT (WRITE_WAIT)
	) mem_ctrl_inst (
		.clk     (clk),
		.rst     (rst),
		.dev_req (dev_req),
		.dev_rsp (dev_rsp)
	);

endmodule

// File: bench/mem_ref_model.svh
// reference copy of the controller memory and expected-value functions, included inside the testbench module

`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// expects mem_op_pkg imported and MEM_WORDS declared by the including module
word_t ref_mem [MEM_WORDS];

// byte address to model slot
// wraps on the depth like the controller does
function automatic int model_slot(input word_t addr);
	return int'((addr >> 2) % MEM_WORDS);
endfunction

// preset contents, word index times 01010101 xor 80402010
function automatic void fill_model();
	for (int i = 0; i < MEM_WORDS; i++) begin
		ref_mem[i] = (32'(i) * 32'h01010101) ^ 32'h80402010;
	end
endfunction

// whole word at a byte address
function automatic word_t ref_word(input word_t addr);
	return ref_mem[model_slot(addr)];
endfunction

// expected data_out for a held load
function automatic word_t ref_load(input mem_op_t op, input word_t addr);
	word_t w;
	w = ref_word(addr);
	case (op)
		MEM_OP_LW:  return w;
		// low byte, sign bit copied upward
		MEM_OP_LBS: return {{24{w[7]}}, w[7:0]};
		MEM_OP_LBU: return {24'h000000, w[7:0]};
		default:    return 32'h00000000;
	endcase
endfunction

// apply a store to the model
// a byte store only replaces bits 7 to 0
function automatic void ref_store(input mem_op_t op, input word_t addr, input word_t wdata);
	int slot;
	slot = model_slot(addr);
	if (op == MEM_OP_SW) begin
		ref_mem[slot] = wdata;
	end else if (op == MEM_OP_SB) begin
		ref_mem[slot] = {ref_mem[slot][31:8], wdata[7:0]};
	end
endfunction

`endif

// File: bench/mem_subsys_tb.sv
// self-checking testbench for the memory subsystem, runs fetches, loads, stores and alignment cases

`timescale 1ns/100ps

module mem_subsys_tb;

	import mem_op_pkg::*;

	localparam int MEM_WORDS  = 256;
	localparam int READ_WAIT  = 1;
	localparam int WRITE_WAIT = 2;

	// operation counts, a store case is preload, store, load back and fetch
	localparam int N_FETCH = 16;
	localparam int N_LOAD  = 24;
	localparam int N_STORE = 16;
	localparam int N_MIS   = 4;
	localparam int N_OPS   = N_FETCH + N_LOAD + 4 * N_STORE + N_MIS;
	localparam int TIMEOUT_CYCLES = 40 * N_OPS;

	`include "mem_ref_model.svh"

	logic      clk;
	logic      rst;
	word_t     instr_addr;
	data_req_t data_req;
	word_t     instr_out;
	word_t     data_out;
	logic      busy;
	logic      misaligned;

	integer seed;
	int     error_count;
	int     check_count;
	int     cycle_count;

	mem_subsys_top #(
		.MEM_WORDS  (MEM_WORDS),
		.READ_WAIT  (READ_WAIT),
		.WRITE_WAIT (WRITE_WAIT)
	) mem_subsys_top_inst (
		.clk        (clk),
		.rst        (rst),
		.instr_addr (instr_addr),
		.instr_out  (instr_out),
		.data_req   (data_req),
		.data_out   (data_out),
		.busy       (busy),
		.misaligned (misaligned)
	);

	always #5 clk = ~clk;

	// random word-aligned address in the low 1 KiB
	// small range so stores and later reads meet
	function automatic word_t rand_word_addr();
		word_t r;
		r = $random(seed);
		return r & 32'h000003fc;
	endfunction

	// wait for the first rising edge with busy low
	task automatic wait_ready();
		@(posedge clk);
		while (busy) begin
			@(posedge clk);
		end
	endtask

	task automatic fetch_word(input word_t addr);
		@(negedge clk);
		instr_addr  = addr;
		data_req.op = MEM_OP_NONE;
		wait_ready();
	endtask

	// load op stays up until the unit stops stalling
	task automatic load_data(input mem_op_t op, input word_t addr);
		@(negedge clk);
		data_req.op   = op;
		data_req.addr = addr;
		wait_ready();
		@(negedge clk);
		data_req.op = MEM_OP_NONE;
	endtask

	task automatic store_data(input mem_op_t op, input word_t addr, input word_t wdata);
		// preload parks the device on the data address so the strobe is taken
		@(negedge clk);
		data_req.op   = MEM_OP_LW;
		data_req.addr = addr;
		wait_ready();
		@(negedge clk);
		data_req.op    = op;
		data_req.wdata = wdata;
		ref_store(op, addr, wdata);
		@(negedge clk);
		data_req.op = MEM_OP_NONE;
		// op dropped so busy now reflects the unit's own sequencing
		// a byte store spends one extra cycle in the merge state
		repeat ((op == MEM_OP_SB) ? 2 : 1) begin
			@(posedge clk);
			assert (busy) else begin
				$display("busy dropped before the store at address %h was written", addr);
				error_count++;
			end
		end
		// addr held until the store has finished
		wait_ready();
	endtask

	// comparison on rising edges, pre-edge values
	always @(posedge clk) begin
		logic exp_mis;
		if (!rst) begin
			check_count++;
			exp_mis = (instr_addr[1:0] != 2'b00) ||
				((data_req.op != MEM_OP_NONE) && (data_req.addr[1:0] != 2'b00));
			assert (misaligned == exp_mis) else begin
				$display("error: misaligned %h expected %h", misaligned, exp_mis);
				error_count++;
			end
			if (mem_op_is_write(data_req.op)) begin
				assert (busy) else begin
					$display("busy was low in the cycle of a store strobe");
					error_count++;
				end
			end
			// results only count once the stall is gone
			if (!busy && mem_op_is_load(data_req.op)) begin
				assert (data_out == ref_load(data_req.op, data_req.addr)) else begin
					$display("error: data_out %h expected %h (op %h addr %h)", data_out,
						ref_load(data_req.op, data_req.addr), data_req.op, data_req.addr);
					error_count++;
				end
			end else if (!busy && (data_req.op == MEM_OP_NONE)) begin
				assert (instr_out == ref_word(instr_addr)) else begin
					$display("error: instr_out %h expected %h (instr_addr %h)", instr_out,
						ref_word(instr_addr), instr_addr);
					error_count++;
				end
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("checks %0d, errors %0d", check_count, error_count + 1);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		word_t   addr;
		word_t   wdata;
		mem_op_t op;
		seed        = 32'h7a43;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		clk         = 1'b0;
		rst         = 1'b1;
		instr_addr  = '0;
		data_req    = '0;
		fill_model();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// plain fetches
		for (int k = 0; k < N_FETCH; k++) begin
			fetch_word(rand_word_addr());
		end

		// loads of every flavour
		// index bit 7, address bit 9, sets bit 7 of the preset low byte
		for (int k = 0; k < N_LOAD; k++) begin
			case (k % 3)
				0:       op = MEM_OP_LW;
				1:       op = MEM_OP_LBS;
				default: op = MEM_OP_LBU;
			endcase
			addr    = rand_word_addr();
			addr[9] = ((k / 3) % 2) == 1;
			load_data(op, addr);
		end

		// word and byte stores, each read back, then a fetch elsewhere
		for (int k = 0; k < N_STORE; k++) begin
			op    = (k % 2 == 0) ? MEM_OP_SW : MEM_OP_SB;
			addr  = rand_word_addr();
			wdata = $random(seed);
			store_data(op, addr, wdata);
			load_data(MEM_OP_LW, addr);
			fetch_word(rand_word_addr());
		end

		// misaligned fetch and data addresses
		fetch_word(rand_word_addr() | 32'h00000002);
		fetch_word(rand_word_addr());
		load_data(MEM_OP_LW, rand_word_addr() | 32'h00000001);
		load_data(MEM_OP_LBU, rand_word_addr() | 32'h00000003);

		@(negedge clk);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: flist.f
common/mem_op_pkg.sv
common/dev_bus_pkg.sv
mmu/mmu.sv
src/mem_ctrl.sv
src/mem_subsys_top.sv
+incdir+bench
bench/mem_subsys_tb.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench

TOP := mem_subsys_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module mem_subsys_top
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# pass is decided by the pass line in the log
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
